//--- Makefile
# Verilator build and run of the address translation testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= addr_translate_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
+incdir+logic
logic/addr_pkg.sv
logic/thread_counter.sv
logic/offset_table.sv
logic/addr_decode.sv
logic/addr_execute.sv
logic/addr_translate.sv
bench/addr_translate_asserts.sv
bench/addr_translate_tb.sv

//--- bench/addr_translate_asserts.sv
/* concurrent checks on the translation stage, bound into the top level
   cover the slot counter, window writes, output reset and the decode class */
`timescale 1ns/1ns
`include "addr_cfg.svh"

module addr_translate_asserts
    import addr_pkg::*;
(
    input logic          clock,
    input logic          arst_n,
    input addr_t         write_addr,
    input addr_t         addr_out,
    input thread_t       current_thread,
    input offset_write_t offset_write,
    input decoded_addr_t decoded
);

    function automatic bit covers(input int base, input int count, input addr_t a);
        int rel;
        rel = int'(a) - base;
        return (rel >= 0) && (rel < count);
    endfunction

    function automatic thread_t following(input thread_t t);
        int n;
        n = (int'(t) + 1) % `THREAD_COUNT;
        return thread_t'(n);
    endfunction

    // ####################
    // slot counter and window writes

    slot_step_check: assert property (@(posedge clock) disable iff (!arst_n)
        1'b1 |=> current_thread == following($past(current_thread)))
        else $error("thread counter did not step to the next slot");

    window_write_check: assert property (@(posedge clock)
        offset_write.wren == covers(int'(`ADDR_OFFSET_BASE), `ADDR_OFFSET_COUNT, write_addr))
        else $error("offset write enable does not match the window decode");

    // ####################
    // output and decode

    reset_output_check: assert property (@(posedge clock) !arst_n |-> addr_out == '0)
        else $error("addr_out is not zero during reset");

    // high memory and I/O never overlap
    raw_class_check: assert property (@(posedge clock)
        decoded.use_raw == (covers(int'(`ADDR_HIGHMEM_BASE), `ADDR_HIGHMEM_COUNT, decoded.addr)
                         || covers(int'(`ADDR_IO_BASE), `ADDR_IO_COUNT, decoded.addr)))
        else $error("use_raw does not match the registered address class");

endmodule

bind addr_translate addr_translate_asserts i_addr_translate_asserts (
    .clock          (clock),
    .arst_n         (arst_n),
    .write_addr     (write_addr),
    .addr_out       (addr_out),
    .current_thread (current_thread),
    .offset_write   (offset_write),
    .decoded        (decoded)
);

//--- bench/addr_translate_tb.sv
/* testbench for the address translation stage, drives one slot per cycle
   and compares addr_out with a reference model two cycles later */
`timescale 1ns/1ns
`include "addr_cfg.svh"

module addr_translate_tb
    import addr_pkg::*;
();

    localparam int PERIOD = 10;
    localparam int RESET_CYCLES = 4;
    localparam int DIRECTED_SLOTS = 120;
    localparam int RANDOM_SLOTS = 400;
    localparam int WATCHDOG_CYCLES = DIRECTED_SLOTS + RANDOM_SLOTS + 2 * RESET_CYCLES + 50;
    localparam int ADDR_SPAN = 1 << `ADDR_WIDTH;
    localparam int HM_BASE = int'(`ADDR_HIGHMEM_BASE);
    localparam int HM_COUNT = `ADDR_HIGHMEM_COUNT;
    localparam int IO_BASE = int'(`ADDR_IO_BASE);
    localparam int IO_COUNT = `ADDR_IO_COUNT;
    localparam int OFF_BASE = int'(`ADDR_OFFSET_BASE);
    localparam int OFF_COUNT = `ADDR_OFFSET_COUNT;

    logic  clock;
    logic  arst_n;
    addr_t addr_in;
    addr_t write_addr;
    addr_t write_data;
    addr_t addr_out;

    // reference model state
    addr_t         model_offset [`THREAD_COUNT];
    logic          offset_known [`THREAD_COUNT];
    offset_write_t write_delay [$];
    addr_t         expected [$];
    logic          expected_valid [$];
    string         slot_test [$];
    int            slot_thread;
    string         test_name;
    logic [31:0]   rng_state;
    int            check_count;
    int            error_count;
    int            reset_error_count;

    addr_translate i_addr_translate (
        .clock      (clock),
        .arst_n     (arst_n),
        .addr_in    (addr_in),
        .write_addr (write_addr),
        .write_data (write_data),
        .addr_out   (addr_out)
    );

    always #(PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic bit covers(input int base, input int count, input addr_t a);
        int rel;
        rel = int'(a) - base;
        return (rel >= 0) && (rel < count);
    endfunction

    // ####################
    // checking

    task automatic check_result();
        addr_t exp;
        logic  valid;
        string name;
        exp = expected.pop_front();
        valid = expected_valid.pop_front();
        name = slot_test.pop_front();
        if (valid) begin
            check_count++;
            assert (addr_out === exp) else begin
                error_count++;
                $display("FAIL %s: expected %h, actual %h", name, exp, addr_out);
            end
        end
    endtask

    // holds reset, table contents survive it in both DUT and model
    task automatic apply_reset();
        arst_n = 1'b0;
        addr_in = '0;
        write_addr = '0;
        write_data = '0;
        expected.delete();
        expected_valid.delete();
        slot_test.delete();
        write_delay.delete();
        repeat (`ADDR_OFFSET_WRITE_DELAY) write_delay.push_back('0);
        // output stays zero until the first slot after release comes out
        repeat (2) begin
            expected.push_back('0);
            expected_valid.push_back(1'b1);
            slot_test.push_back("reset_release");
        end
        slot_thread = `ADDR_INITIAL_THREAD;
        repeat (RESET_CYCLES) begin
            @(negedge clock);
            assert (addr_out === '0) else begin
                reset_error_count++;
                $display("FAIL reset: expected %h, actual %h", addr_t'(0), addr_out);
            end
        end
        arst_n = 1'b1;
    endtask

    // ####################
    // one slot: check, drive, predict

    task automatic drive_slot(input addr_t a, input addr_t waddr, input addr_t wdata);
        offset_write_t landing;
        offset_write_t issued;
        logic          raw;
        int            sum;
        if (expected.size() == 2) begin
            check_result();
        end
        addr_in = a;
        write_addr = waddr;
        write_data = wdata;
        raw = covers(HM_BASE, HM_COUNT, a) || covers(IO_BASE, IO_COUNT, a);
        sum = (int'(a) + int'(model_offset[slot_thread])) % ADDR_SPAN;
        expected.push_back(raw ? a : addr_t'(sum));
        expected_valid.push_back(raw || offset_known[slot_thread]);
        slot_test.push_back(test_name);
        // the table is read before a write landing at the same edge
        landing = write_delay.pop_front();
        if (landing.wren) begin
            model_offset[landing.thread] = landing.data;
            offset_known[landing.thread] = 1'b1;
        end
        issued.wren = covers(OFF_BASE, OFF_COUNT, waddr);
        issued.thread = thread_t'(slot_thread);
        issued.data = wdata;
        write_delay.push_back(issued);
        slot_thread = (slot_thread + 1) % `THREAD_COUNT;
        @(negedge clock);
    endtask

    task automatic flush_pipeline();
        repeat (2) drive_slot(addr_t'(HM_BASE), '0, '0);
    endtask

    // every thread writes its own offset, addresses stay raw meanwhile
    task automatic load_offsets(input int first, input int step);
        for (int i = 0; i < `THREAD_COUNT; i++) begin
            drive_slot(addr_t'(HM_BASE + 16 * i), addr_t'(OFF_BASE + slot_thread % OFF_COUNT),
                       addr_t'(first + step * slot_thread));
        end
    endtask

    task automatic raw_boundaries();
        int edges [7];
        edges = '{IO_BASE - 1, IO_BASE, IO_BASE + IO_COUNT - 1, HM_BASE,
                  HM_BASE + HM_COUNT - 1, HM_BASE + HM_COUNT, OFF_BASE};
        for (int i = 0; i < 14; i++) begin
            drive_slot(addr_t'(edges[i % 7]), '0, '0);
        end
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        addr_t       a;
        addr_t       waddr;
        for (int i = 0; i < RANDOM_SLOTS; i++) begin
            r = next_random();
            case (r[1:0])
                2'd0:    a = addr_t'(HM_BASE + int'(r[11:2]) % HM_COUNT);
                2'd1:    a = addr_t'(IO_BASE + int'(r[5:2]) % IO_COUNT);
                default: a = addr_t'(r[31:20]);
            endcase
            if (r[19:16] == 4'h0) begin
                waddr = addr_t'(OFF_BASE + int'(r[15:8]) % OFF_COUNT);
            end else begin
                waddr = addr_t'(r[15:4]);
            end
            drive_slot(a, waddr, addr_t'(next_random()));
        end
    endtask

    // ####################
    // watchdog

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        clock = 1'b0;
        arst_n = 1'b0;
        addr_in = '0;
        write_addr = '0;
        write_data = '0;
        rng_state = 32'h6690cf26;
        check_count = 0;
        error_count = 0;
        reset_error_count = 0;
        foreach (offset_known[t]) begin
            offset_known[t] = 1'b0;
            model_offset[t] = '0;
        end

        test_name = "reset";
        apply_reset();
        test_name = "load";
        load_offsets('h105, 'h111);
        test_name = "private";
        for (int i = 0; i < 16; i++) begin
            drive_slot(addr_t'(16 * i + 3), '0, '0);
        end
        flush_pipeline();
        test_name = "reset_keep";
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            drive_slot(addr_t'(40 * i + 7), '0, '0);
        end
        test_name = "raw_ranges";
        raw_boundaries();
        test_name = "wrap";
        load_offsets('hFF0, -'h011);
        for (int i = 0; i < 8; i++) begin
            drive_slot(addr_t'(12'h0A0 + 12'h040 * i), '0, '0);
        end
        test_name = "outside_window";
        for (int i = 0; i < 12; i++) begin
            drive_slot(addr_t'(12'h200 + 9 * i),
                       addr_t'(i % 2 == 0 ? OFF_BASE - 1 : OFF_BASE + OFF_COUNT),
                       addr_t'(next_random()));
        end
        test_name = "rewrite";
        for (int i = 0; i < 12; i++) begin
            drive_slot(addr_t'(12'h300 + 5 * i), i == 1 ? addr_t'(OFF_BASE) : addr_t'(0),
                       addr_t'(12'h7A5));
        end
        test_name = "random";
        random_traffic();
        flush_pipeline();

        $display("checks %0d, result errors %0d, reset errors %0d",
                 check_count, error_count, reset_error_count);
        if (error_count == 0 && reset_error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- logic/addr_cfg.svh
/* widths, thread count, address map and write delay of the address translation stage
   include wherever one of these values is needed */
`ifndef ADDR_CFG_SVH
`define ADDR_CFG_SVH

// ####################
// widths
`define ADDR_WIDTH              12
`define THREAD_WIDTH            2

// ####################
// threads
`define THREAD_COUNT            4
`define ADDR_INITIAL_THREAD     0

// ####################
// address map, high memory and I/O never overlap
`define ADDR_HIGHMEM_BASE       12'hC00
`define ADDR_HIGHMEM_COUNT      1024
`define ADDR_IO_BASE            12'hBF0
`define ADDR_IO_COUNT           16
// one offset word per thread
`define ADDR_OFFSET_BASE        12'hBE0
`define ADDR_OFFSET_COUNT       4

// cycles from write acceptance to table update
`define ADDR_OFFSET_WRITE_DELAY 1

`endif

//--- logic/addr_decode.sv
/* decode stage, classifies the address against the map and registers it
   also spots writes into the offset window and tags them with the slot owner */
`timescale 1ns/1ns
`include "addr_cfg.svh"

module addr_decode
    import addr_pkg::*;
(
    input  logic          clock,
    input  logic          arst_n,
    input  addr_t         addr_in,
    input  addr_t         write_addr,
    input  addr_t         write_data,
    input  thread_t       current_thread,
    output decoded_addr_t decoded,
    output offset_write_t offset_write
);

    logic in_highmem;
    logic in_io;
    logic in_window;

    // compare as int, high memory ends past the top of a 12 bit address
    function automatic logic in_range(input addr_t addr, input int base, input int count);
        int addr_int;
        addr_int = int'(addr);
        return (addr_int >= base) && (addr_int < base + count);
    endfunction

    // ####################
    // read address

    assign in_highmem = in_range(addr_in, int'(`ADDR_HIGHMEM_BASE), `ADDR_HIGHMEM_COUNT);
    assign in_io      = in_range(addr_in, int'(`ADDR_IO_BASE), `ADDR_IO_COUNT);

    // ranges are disjoint, so either hit means raw
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            decoded <= '0;
        end else begin
            decoded.addr    <= addr_in;
            decoded.use_raw <= in_highmem | in_io;
        end
    end

    // ####################
    // offset write

    assign in_window = in_range(write_addr, int'(`ADDR_OFFSET_BASE), `ADDR_OFFSET_COUNT);

    // any word in the window sets the issuing thread's own entry
    always_comb begin
        offset_write.wren   = in_window;
        offset_write.thread = current_thread;
        offset_write.data   = write_data;
    end

endmodule

//--- logic/addr_execute.sv
/* execute stage, adds the thread offset and registers the final address
   raw addresses bypass the adder through the same output register */
`timescale 1ns/1ns
`include "addr_cfg.svh"

module addr_execute
    import addr_pkg::*;
(
    input  logic          clock,
    input  logic          arst_n,
    input  decoded_addr_t decoded,
    input  addr_t         offset,
    output addr_t         addr_out
);

    addr_t offset_addr;

    // carry out of the top bit is dropped, so the sum wraps
    always_comb begin
        offset_addr = decoded.addr + offset;
    end

    // ####################
    // result select

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            addr_out <= '0;
        end else if (decoded.use_raw) begin
            addr_out <= decoded.addr;
        end else begin
            addr_out <= offset_addr;
        end
    end

endmodule

//--- logic/addr_pkg.sv
/* types shared by the stages of the address translation pipeline
   import with a wildcard in the module header */
`include "addr_cfg.svh"

package addr_pkg;

    // ####################
    // plain vectors

    // address, or an offset added to one
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // hardware thread number
    typedef logic [`THREAD_WIDTH-1:0] thread_t;

    // ####################
    // stage payloads

    // decode to execute
    typedef struct packed {
        addr_t addr;
        logic  use_raw;
    } decoded_addr_t;

    // decode to offset table, thread is the slot owner
    typedef struct packed {
        logic    wren;
        thread_t thread;
        addr_t   data;
    } offset_write_t;

endpackage

//--- logic/addr_translate.sv
/* address translation stage of the barrel processor, two cycles from addr_in to addr_out
   writes into the offset window set the issuing thread's private data offset */
`timescale 1ns/1ns
`include "addr_cfg.svh"

module addr_translate
    import addr_pkg::*;
(
    input  logic  clock,
    input  logic  arst_n,
    input  addr_t addr_in,
    input  addr_t write_addr,
    input  addr_t write_data,
    output addr_t addr_out
);

    thread_t       current_thread;
    decoded_addr_t decoded;
    offset_write_t offset_write;
    addr_t         offset;

    // ####################
    // slot owner

    thread_counter i_thread_counter (
        .clock          (clock),
        .arst_n         (arst_n),
        .current_thread (current_thread)
    );

    // ####################
    // first stage, decode and table read in parallel

    addr_decode i_addr_decode (
        .clock          (clock),
        .arst_n         (arst_n),
        .addr_in        (addr_in),
        .write_addr     (write_addr),
        .write_data     (write_data),
        .current_thread (current_thread),
        .decoded        (decoded),
        .offset_write   (offset_write)
    );

    offset_table i_offset_table (
        .clock          (clock),
        .arst_n         (arst_n),
        .offset_write   (offset_write),
        .current_thread (current_thread),
        .offset         (offset)
    );

    // ####################
    // second stage

    addr_execute i_addr_execute (
        .clock    (clock),
        .arst_n   (arst_n),
        .decoded  (decoded),
        .offset   (offset),
        .addr_out (addr_out)
    );

endmodule

//--- logic/offset_table.sv
/* per-thread offset storage with a delayed write port and a registered read port
   read with the slot owner, written by window writes tagged in decode */
`timescale 1ns/1ns
`include "addr_cfg.svh"

module offset_table
    import addr_pkg::*;
(
    input  logic          clock,
    input  logic          arst_n,
    input  offset_write_t offset_write,
    input  thread_t       current_thread,
    output addr_t         offset
);

    localparam int DELAY = `ADDR_OFFSET_WRITE_DELAY;

    // stage 0 is the incoming write, the last stage drives the array
    offset_write_t write_pipe [0:DELAY];
    addr_t         offsets [`THREAD_COUNT];

    assign write_pipe[0] = offset_write;

    // ####################
    // write delay line

    for (genvar i = 1; i <= DELAY; i++) begin : g_write_stage
        always_ff @(posedge clock or negedge arst_n) begin
            if (!arst_n) begin
                write_pipe[i] <= '0;
            end else begin
                write_pipe[i] <= write_pipe[i-1];
            end
        end
    end

    // ####################
    // storage

    always_ff @(posedge clock) begin
        if (write_pipe[DELAY].wren) begin
            offsets[write_pipe[DELAY].thread] <= write_pipe[DELAY].data;
        end
    end

    // lines up with the decode register of the same slot
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            offset <= '0;
        end else begin
            offset <= offsets[current_thread];
        end
    end

endmodule

//--- logic/thread_counter.sv
/* round-robin slot counter, one thread owns each cycle
   shared by decode and the offset table so both agree on the slot owner */
`timescale 1ns/1ns
`include "addr_cfg.svh"

module thread_counter
    import addr_pkg::*;
(
    input  logic    clock,
    input  logic    arst_n,
    output thread_t current_thread
);

    localparam thread_t LAST_THREAD    = thread_t'(`THREAD_COUNT - 1);
    localparam thread_t INITIAL_THREAD = thread_t'(`ADDR_INITIAL_THREAD);

    // wrap explicitly, thread count need not be a power of two
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            current_thread <= INITIAL_THREAD;
        end else if (current_thread == LAST_THREAD) begin
            current_thread <= '0;
        end else begin
            current_thread <= current_thread + thread_t'(1);
        end
    end

endmodule
